// File: design/frame_align_ctrl.sv
/*
 * frame alignment control
 * first pixel FSM finds the start of a buffered frame and opens fifo
 * writes, display FSM pulses the bridge reset for one cycle and then
 * pops the fifo on every requested pixel
 */
`timescale 1ns/1ns

module frame_align_ctrl import vga_pkg::*; (
	input  logic            VGA_CLK,
	input  logic            i_arst_n,
	input  logic            i_buffered,
	input  logic            i_req,
	pixel_stream_if.sink    i_stream,
	output logic            o_wr_en,
	output logic            o_rd_en,
	output logic            o_mon_reset
);

	first_state_e fp_state;
	first_state_e fp_next;
	disp_state_e  ds_state;
	disp_state_e  ds_next;

	// ========================================
	// first pixel FSM
	// ========================================
	always_comb begin
		fp_next = fp_state;
		case (fp_state)
			FP_OFF: begin
				if (i_stream.valid && i_stream.first)
					fp_next = FP_ACTIVE;
				else if (i_stream.valid)
					fp_next = FP_IDLE;
			end
			FP_IDLE: begin
				if (i_stream.valid && i_stream.first)
					fp_next = FP_ACTIVE;
			end
			// hold until the mode changes
			FP_ACTIVE: fp_next = FP_ACTIVE;
			default:   fp_next = FP_OFF;
		endcase
		if (!i_buffered)
			fp_next = FP_OFF;
	end

	// ========================================
	// display FSM
	// ========================================
	always_comb begin
		ds_next = ds_state;
		case (ds_state)
			DS_OFF: begin
				if (fp_state == FP_ACTIVE)
					ds_next = DS_MON_RESET;
			end
			// single cycle pulse
			DS_MON_RESET: ds_next = DS_OUTPUT;
			DS_OUTPUT:    ds_next = DS_OUTPUT;
			default:      ds_next = DS_OFF;
		endcase
		if (!i_buffered)
			ds_next = DS_OFF;
	end

	always_ff @(posedge VGA_CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			fp_state <= FP_OFF;
			ds_state <= DS_OFF;
		end else begin
			fp_state <= fp_next;
			ds_state <= ds_next;
		end
	end

	// write the flagged pixel itself and everything valid after it
	assign o_wr_en = i_buffered && i_stream.valid &&
	                 ((fp_state == FP_ACTIVE) || i_stream.first);
	assign o_rd_en     = (ds_state == DS_OUTPUT) && i_req;
	assign o_mon_reset = (ds_state == DS_MON_RESET);

	// bridge sees exactly one reset cycle per buffered session
	a_mon_pulse: assert property (@(posedge VGA_CLK) disable iff (!i_arst_n)
		o_mon_reset |=> !o_mon_reset);

endmodule

// File: design/pixel_fifo.sv
/*
 * single clock pixel fifo
 * circular buffer with wrap-bit pointers, writes dropped when full,
 * reads dropped when empty, read data registered
 */
`timescale 1ns/1ns

module pixel_fifo import vga_pkg::*; #(
	parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
	input  logic VGA_CLK,
	input  logic i_arst_n,
	input  logic i_wr,
	input  logic i_rd,
	input  rgb_t i_data,
	output rgb_t o_q,
	output logic o_empty,
	output logic o_full
);

	localparam int AW = $clog2(FIFO_DEPTH);

	rgb_t mem [FIFO_DEPTH];

	// extra top bit tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        wr_ok;
	logic        rd_ok;

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) &&
	                 (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// guarded strobes
	assign wr_ok = i_wr && !o_full;
	assign rd_ok = i_rd && !o_empty;

	always_ff @(posedge VGA_CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// storage and output register
	always_ff @(posedge VGA_CLK) begin
		if (wr_ok)
			mem[wr_ptr[AW-1:0]] <= i_data;
		if (rd_ok)
			o_q <= mem[rd_ptr[AW-1:0]];
	end

	a_no_overflow: assert property (@(posedge VGA_CLK) disable iff (!i_arst_n)
		i_wr |-> !o_full);

	a_no_underflow: assert property (@(posedge VGA_CLK) disable iff (!i_arst_n)
		i_rd |-> !o_empty);

endmodule

// File: design/pixel_pipe.sv
/*
 * three stage pixel pipeline
 * stage 1 captures the camera pixel, stage 2 optionally converts to
 * grey, stage 3 registers the result. direct mode advances every cycle,
 * buffered mode advances only behind requested pixels
 */
`timescale 1ns/1ns

module pixel_pipe import vga_pkg::*; (
	input  logic                  VGA_CLK,
	input  logic                  i_arst_n,
	input  rgb_t                  i_pix,
	input  logic                  i_req,
	input  logic                  i_first,
	input  logic                  i_buffered,
	input  logic                  i_grey,
	pixel_stream_if.source        o_stream
);

	// stage load enables
	logic ld1;
	logic ld2;
	logic ld3;

	logic s1_valid;
	logic s1_first;
	logic s2_valid;
	logic s2_first;
	logic s2_grey;
	logic s3_valid;
	logic s3_first;
	logic s3_grey;

	rgb_t s1_pix;
	rgb_t s2_pix;
	rgb_t s3_pix;

	// grey stage
	logic [9:0] luma_sum;
	chan_t      luma;
	rgb_t       s2_next;

	// ========================================
	// load control
	// ========================================
	// direct mode, all stages every cycle
	assign ld1 = !i_buffered || i_req;
	assign ld2 = !i_buffered || s1_valid;
	assign ld3 = !i_buffered || s2_valid;

	// valid marks a freshly loaded stage, first only rides in buffered mode
	always_ff @(posedge VGA_CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			s1_valid <= 1'b0;
			s1_first <= 1'b0;
			s2_valid <= 1'b0;
			s2_first <= 1'b0;
			s2_grey  <= 1'b0;
			s3_valid <= 1'b0;
			s3_first <= 1'b0;
			s3_grey  <= 1'b0;
		end else begin
			s1_valid <= ld1;
			s1_first <= i_buffered && i_req && i_first;
			s2_valid <= ld2;
			s2_first <= i_buffered && s1_valid && s1_first;
			s3_valid <= ld3;
			s3_first <= i_buffered && s2_valid && s2_first;
			if (ld2)
				s2_grey <= i_grey;
			if (ld3)
				s3_grey <= s2_grey;
		end
	end

	// ========================================
	// grey conversion, (r + 2g + b) / 4
	// ========================================
	assign luma_sum = {2'b00, s1_pix[23:16]} + {1'b0, s1_pix[15:8], 1'b0} +
	                  {2'b00, s1_pix[7:0]};
	// max 1020, top byte always fits
	assign luma     = luma_sum[9:2];
	assign s2_next  = i_grey ? {luma, luma, luma} : s1_pix;

	// ========================================
	// data stages
	// ========================================
	always_ff @(posedge VGA_CLK) begin
		if (ld1)
			s1_pix <= i_pix;
		if (ld2)
			s2_pix <= s2_next;
		if (ld3)
			s3_pix <= s2_pix;
	end

	assign o_stream.valid = s3_valid;
	assign o_stream.first = s3_first;
	assign o_stream.pix   = s3_pix;
	assign o_stream.grey  = s3_grey;

endmodule

// File: design/pixel_stream_if.sv
/*
 * pixel stream between the pipeline and its consumers
 * one pixel per stage output with valid, first-of-frame and grey flags,
 * no back-pressure, a stage advances or holds
 */
`timescale 1ns/1ns

interface pixel_stream_if import vga_pkg::*; ();

	// requested pixel, or any pixel in direct mode
	logic valid;
	// first pixel of a frame, buffered mode only
	logic first;
	// pixel data
	rgb_t pix;
	// pixel went through the grey stage
	logic grey;

	modport source (output valid, output first, output pix, output grey);

	modport sink (input valid, input first, input pix, input grey);

endinterface

// File: design/raster_timing.sv
/*
 * vga raster timing
 * free running x / y counters over the 800 x 525 frame, sync,
 * blanking and pixel request decoded straight from the counts
 */
`timescale 1ns/1ns

module raster_timing import vga_pkg::*; (
	input  logic VGA_CLK,
	input  logic i_arst_n,
	output logic o_hs,
	output logic o_vs,
	output logic o_blank_n,
	output logic o_req,
	output logic o_first,
	output cnt_t o_x,
	output cnt_t o_y
);

	cnt_t x_cnt;
	cnt_t y_cnt;
	logic x_wrap;

	// ========================================
	// counters
	// ========================================
	assign x_wrap = (x_cnt == H_TOTAL - 13'd1);

	always_ff @(posedge VGA_CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			x_cnt <= '0;
			y_cnt <= '0;
		end else begin
			if (x_wrap) begin
				x_cnt <= '0;
				// y steps once per line
				if (y_cnt == V_TOTAL - 13'd1)
					y_cnt <= '0;
				else
					y_cnt <= y_cnt + 13'd1;
			end else begin
				x_cnt <= x_cnt + 13'd1;
			end
		end
	end

	// ========================================
	// decode, same cycle as the count
	// ========================================
	// active low syncs
	assign o_hs = !((x_cnt >= HS_START) && (x_cnt <= HS_END));
	assign o_vs = !((y_cnt >= VS_START) && (y_cnt <= VS_END));

	// blank until both axes leave their porch
	assign o_blank_n = !((x_cnt < H_BLANK_END) || (y_cnt < V_BLANK_END));

	// request window
	assign o_req = (x_cnt > H_BLANK_END) && (x_cnt < H_TOTAL) &&
	               (y_cnt > V_BLANK_END) && (y_cnt < V_TOTAL);

	// top left requested pixel
	assign o_first = o_req && (x_cnt == H_BLANK_END + 13'd1) &&
	                 (y_cnt == V_BLANK_END + 13'd1);

	assign o_x = x_cnt;
	assign o_y = y_cnt;

	// x wraps before the line total, else the decode windows slip
	a_x_range: assert property (@(posedge VGA_CLK) disable iff (!i_arst_n)
		x_cnt < H_TOTAL);

endmodule

// File: design/vga_pix_pipe.sv
/*
 * vga side pixel path, top level
 * mode decode, raster timing, pixel pipeline, frame alignment and the
 * re-timing fifo. buffered modes drive the monitor from the fifo,
 * direct modes straight from pipeline stage 3
 */
`timescale 1ns/1ns

module vga_pix_pipe import vga_pkg::*; #(
	parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
	input  logic       VGA_CLK,
	input  logic       i_arst_n,
	input  logic [2:0] i_mode,
	input  chan_t      i_cam_r,
	input  chan_t      i_cam_g,
	input  chan_t      i_cam_b,
	output chan_t      o_vga_r,
	output chan_t      o_vga_g,
	output chan_t      o_vga_b,
	output logic       o_vga_hs,
	output logic       o_vga_vs,
	output logic       o_vga_blank_n,
	output logic       o_pix_req,
	output logic       o_mon_reset
);

	mode_e mode;
	logic  buffered;
	logic  grey;
	logic  req;
	logic  first;
	cnt_t  x_cnt;
	cnt_t  y_cnt;
	logic  wr_en;
	logic  rd_en;
	logic  fifo_empty;
	logic  fifo_full;
	rgb_t  fifo_q;
	rgb_t  out_pix;

	pixel_stream_if stream_if ();

	// ========================================
	// mode decode
	// ========================================
	assign mode = mode_e'(i_mode);

	always_comb begin
		buffered = 1'b0;
		grey     = 1'b0;
		case (mode)
			MODE_GREY: grey = 1'b1;
			// former filter codes, now plain buffered route
			MODE_BUF_A, MODE_BUF_B, MODE_BUF_C: buffered = 1'b1;
			// normal and unused codes pass through
			default: grey = 1'b0;
		endcase
	end

	raster_timing raster_i (
		.VGA_CLK   (VGA_CLK),
		.i_arst_n  (i_arst_n),
		.o_hs      (o_vga_hs),
		.o_vs      (o_vga_vs),
		.o_blank_n (o_vga_blank_n),
		.o_req     (req),
		.o_first   (first),
		.o_x       (x_cnt),
		.o_y       (y_cnt)
	);

	pixel_pipe pipe_i (
		.VGA_CLK    (VGA_CLK),
		.i_arst_n   (i_arst_n),
		.i_pix      ({i_cam_r, i_cam_g, i_cam_b}),
		.i_req      (req),
		.i_first    (first),
		.i_buffered (buffered),
		.i_grey     (grey),
		.o_stream   (stream_if.source)
	);

	frame_align_ctrl align_i (
		.VGA_CLK     (VGA_CLK),
		.i_arst_n    (i_arst_n),
		.i_buffered  (buffered),
		.i_req       (req),
		.i_stream    (stream_if.sink),
		.o_wr_en     (wr_en),
		.o_rd_en     (rd_en),
		.o_mon_reset (o_mon_reset)
	);

	pixel_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) fifo_i (
		.VGA_CLK  (VGA_CLK),
		.i_arst_n (i_arst_n),
		.i_wr     (wr_en),
		.i_rd     (rd_en),
		.i_data   (stream_if.pix),
		.o_q      (fifo_q),
		.o_empty  (fifo_empty),
		.o_full   (fifo_full)
	);

	// ========================================
	// output route
	// ========================================
	assign out_pix   = buffered ? fifo_q : stream_if.pix;
	assign o_vga_r   = out_pix[23:16];
	assign o_vga_g   = out_pix[15:8];
	assign o_vga_b   = out_pix[7:0];
	assign o_pix_req = req;

	// bridge reset only on the first request row, after the pipe fill
	a_pulse_pos: assert property (@(posedge VGA_CLK) disable iff (!i_arst_n)
		o_mon_reset |-> (y_cnt == V_BLANK_END + 13'd1) && (x_cnt > H_BLANK_END));

	// popping display never meets a dry or overrun fifo
	a_fifo_ok: assert property (@(posedge VGA_CLK) disable iff (!i_arst_n)
		rd_en |-> !fifo_empty && !fifo_full);

	// no grey pixel ever enters the fifo on the unfiltered buffered route
	a_no_grey_wr: assert property (@(posedge VGA_CLK) disable iff (!i_arst_n)
		wr_en |-> !stream_if.grey);

endmodule

// File: design/vga_pkg.sv
/*
 * vga pixel path shared definitions
 * pixel and counter types, raster thresholds of the 800 x 525 frame,
 * processing mode codes and the frame alignment FSM encodings
 */
package vga_pkg;

	// ========================================
	// types
	// ========================================
	// one colour channel
	typedef logic [7:0]  chan_t;
	// packed pixel, red in the top byte, blue in the bottom
	typedef logic [23:0] rgb_t;
	// raster x / y count
	typedef logic [12:0] cnt_t;

	// ========================================
	// raster thresholds
	// ========================================
	localparam cnt_t H_TOTAL     = 13'd800;
	localparam cnt_t V_TOTAL     = 13'd525;
	// sync pulses, low inside the range
	localparam cnt_t HS_START    = 13'd2;
	localparam cnt_t HS_END      = 13'd97;
	localparam cnt_t VS_START    = 13'd13;
	localparam cnt_t VS_END      = 13'd14;
	// end of blanking on each axis
	localparam cnt_t H_BLANK_END = 13'd160;
	localparam cnt_t V_BLANK_END = 13'd45;

	// pixel fifo, any power of two works
	localparam int FIFO_DEPTH_DEF = 2048;

	// ========================================
	// mode and state encodings
	// ========================================
	// codes not listed fall back to normal
	typedef enum logic [2:0] {
		MODE_NORMAL = 3'b000,
		MODE_GREY   = 3'b001,
		MODE_BUF_A  = 3'b100,
		MODE_BUF_B  = 3'b101,
		MODE_BUF_C  = 3'b110
	} mode_e;

	// first pixel search
	typedef enum logic [1:0] {FP_OFF, FP_IDLE, FP_ACTIVE} first_state_e;

	// display start sequence
	typedef enum logic [1:0] {DS_OFF, DS_MON_RESET, DS_OUTPUT} disp_state_e;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the vga pixel path testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_vga_pix_pipe \
	-f vga_pix_pipe.f \
	-Mdir obj_dir

# the simulator exits non-zero on a fatal check, the log decides
./obj_dir/Vtb_vga_pix_pipe > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	exit 0
else
	exit 1
fi

// File: tests/tb_vga_pix_pipe.sv
/*
 * testbench for the vga pixel path
 * raster timing against a model counter, direct and grey pipelines
 * against a 3 cycle history, buffered route against the queue of
 * requested camera pixels
 */
`timescale 1ns/1ns

module tb_vga_pix_pipe import vga_pkg::*; ();

	localparam int FRAME_CYCLES = 800 * 525;
	localparam int NUM_POPS     = 2000;
	localparam int BUF_TIMEOUT  = FRAME_CYCLES + 20000;

	logic       VGA_CLK;
	logic       i_arst_n;
	logic [2:0] i_mode;
	chan_t      i_cam_r;
	chan_t      i_cam_g;
	chan_t      i_cam_b;
	chan_t      o_vga_r;
	chan_t      o_vga_g;
	chan_t      o_vga_b;
	logic       o_vga_hs;
	logic       o_vga_vs;
	logic       o_vga_blank_n;
	logic       o_pix_req;
	logic       o_mon_reset;

	// model raster count, stepped on the falling edge
	cnt_t mx;
	cnt_t my;

	vga_pix_pipe dut_i (
		.VGA_CLK       (VGA_CLK),
		.i_arst_n      (i_arst_n),
		.i_mode        (i_mode),
		.i_cam_r       (i_cam_r),
		.i_cam_g       (i_cam_g),
		.i_cam_b       (i_cam_b),
		.o_vga_r       (o_vga_r),
		.o_vga_g       (o_vga_g),
		.o_vga_b       (o_vga_b),
		.o_vga_hs      (o_vga_hs),
		.o_vga_vs      (o_vga_vs),
		.o_vga_blank_n (o_vga_blank_n),
		.o_pix_req     (o_pix_req),
		.o_mon_reset   (o_mon_reset)
	);

	initial begin : clk_gen
		VGA_CLK = 1'b0;
		forever #5 VGA_CLK = ~VGA_CLK;
	end

	// ========================================
	// reference model
	// ========================================
	// syncs low inside their ranges
	function automatic logic hs_level(input cnt_t x);
		return !(x >= 13'd2 && x <= 13'd97);
	endfunction

	function automatic logic vs_level(input cnt_t y);
		return !(y >= 13'd13 && y <= 13'd14);
	endfunction

	function automatic logic blank_level(input cnt_t x, input cnt_t y);
		return !(x < 13'd160 || y < 13'd45);
	endfunction

	function automatic logic in_req_window(input cnt_t x, input cnt_t y);
		return (x > 13'd160) && (y > 13'd45) && (y < 13'd525);
	endfunction

	// (r + 2g + b) / 4 on every channel
	function automatic rgb_t grey_of(input rgb_t p);
		int    sum;
		chan_t g;
		sum = int'(p[23:16]) + 2 * int'(p[15:8]) + int'(p[7:0]);
		g   = chan_t'(sum / 4);
		return {g, g, g};
	endfunction

	// ========================================
	// helpers and compare tasks
	// ========================================
	function automatic rgb_t next_pixel();
		return rgb_t'($urandom & 32'h00ff_ffff);
	endfunction

	function automatic rgb_t out_rgb();
		return {o_vga_r, o_vga_g, o_vga_b};
	endfunction

	task automatic drive_pix(input rgb_t p);
		i_cam_r = p[23:16];
		i_cam_g = p[15:8];
		i_cam_b = p[7:0];
	endtask

	task automatic stop_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic fail_plain(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		stop_run();
	endtask

	task automatic chk_pix(input rgb_t got, input rgb_t exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got %06h expected %06h",
			         $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic chk_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	// ========================================
	// raster compare process
	// ========================================
	initial begin : raster_mon
		int   n;
		logic running;
		mx      = '0;
		my      = '0;
		running = 1'b0;
		for (n = 0; n < 100 && !running; n++) begin
			@(negedge VGA_CLK);
			running = (i_arst_n === 1'b1);
		end
		if (!running)
			fail_plain("reset was never released");
		forever begin
			chk_bit(o_vga_hs, hs_level(mx), "hsync");
			chk_bit(o_vga_vs, vs_level(my), "vsync");
			chk_bit(o_vga_blank_n, blank_level(mx, my), "blank_n");
			chk_bit(o_pix_req, in_req_window(mx, my), "pixel request");
			// model count, same wrap as the raster
			if (mx == 13'd799) begin
				mx = '0;
				my = (my == 13'd524) ? 13'd0 : my + 13'd1;
			end else begin
				mx = mx + 13'd1;
			end
			@(negedge VGA_CLK);
		end
	end

	// ========================================
	// direct modes, output is the input 3 cycles back
	// ========================================
	task automatic run_direct(input mode_e mode, input int cycles);
		rgb_t pix;
		rgb_t exp_q[$];
		int   n;
		for (n = 0; n < cycles; n++) begin
			@(posedge VGA_CLK);
			#1;
			if (exp_q.size() == 3)
				chk_pix(out_rgb(), exp_q.pop_front(), "direct pipeline");
			chk_bit(o_mon_reset, 1'b0, "mon_reset outside buffered mode");
			pix    = next_pixel();
			i_mode = mode;
			drive_pix(pix);
			exp_q.push_back((mode == MODE_GREY) ? grey_of(pix) : pix);
		end
	endtask

	// ========================================
	// buffered mode, fifo pops follow the requested pixels
	// ========================================
	task automatic run_buffered();
		rgb_t pix;
		rgb_t exp_q[$];
		int   n;
		int   pops;
		int   pulses;
		logic started;
		logic pop_pend;
		logic prev_mr;
		logic req_now;
		pops     = 0;
		pulses   = 0;
		started  = 1'b0;
		pop_pend = 1'b0;
		prev_mr  = 1'b0;
		for (n = 0; n < BUF_TIMEOUT && pops < NUM_POPS; n++) begin
			@(posedge VGA_CLK);
			#1;
			// word popped on the last request shows now
			if (pop_pend) begin
				if (exp_q.size() == 0)
					fail_plain("fifo popped with no camera pixel queued");
				else
					chk_pix(out_rgb(), exp_q.pop_front(), "fifo pop");
				pops++;
			end
			if (o_mon_reset) begin
				if (prev_mr)
					fail_plain("mon_reset held high for two cycles");
				pulses++;
			end
			if (pulses > 1)
				fail_plain("second mon_reset pulse in one buffered session");
			if (pulses == 0 && n >= FRAME_CYCLES)
				fail_plain("no mon_reset pulse within one frame");
			prev_mr  = o_mon_reset;
			req_now  = in_req_window(mx, my);
			pop_pend = (pulses == 1) && !o_mon_reset && req_now;
			pix      = next_pixel();
			i_mode   = MODE_BUF_A;
			drive_pix(pix);
			// queue from the top left request pixel on
			if (req_now && mx == 13'd161 && my == 13'd46)
				started = 1'b1;
			if (started && req_now)
				exp_q.push_back(pix);
		end
		if (pops < NUM_POPS)
			fail_plain("timed out waiting for buffered pixels");
	endtask

	initial begin : main
		int n;
		void'($urandom(55019));
		i_arst_n = 1'b0;
		i_mode   = 3'b000;
		drive_pix(24'h000000);
		for (n = 0; n < 10; n++) begin
			@(posedge VGA_CLK);
			#1;
			chk_bit(o_mon_reset, 1'b0, "mon_reset during reset");
		end
		i_arst_n = 1'b1;
		run_direct(MODE_NORMAL, 300);
		run_direct(MODE_GREY, 300);
		run_direct(MODE_NORMAL, 40);
		// still early in frame 0, well before the first request row
		run_buffered();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: vga_pix_pipe.f
design/vga_pkg.sv
design/pixel_stream_if.sv
design/raster_timing.sv
design/pixel_pipe.sv
design/frame_align_ctrl.sv
design/pixel_fifo.sv
design/vga_pix_pipe.sv
tests/tb_vga_pix_pipe.sv
